// File: build.f
verilog/memOpPkg.sv
verilog/memOpDecoder.sv
verilog/memOpExecute.sv
verilog/memOpResult.sv
verilog/memOpUnit.sv
verification/memOpUnitTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, then judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module memOpUnitTb -f build.f \
	-o memOpUnitSim && ./obj_dir/memOpUnitSim | tee sim.log || { echo "Build or run error"; exit 1; }

grep -q "Test failures found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: verification/memOpUnitTb.sv
`timescale 1ns/1ps

module memOpUnitTb import memOpPkg::*; ();

// One table row drives one full four-phase transaction
typedef struct packed {
	logic [6:0]  opcode;
	logic [2:0]  sizeFunc;
	logic [31:0] base;
	logic [11:0] disp;
	logic        expFault;
	logic [3:0]  holdCycles;
} testRow_t;

logic       clk;
logic       rstN;
logic       req;
memReq_t    request;
logic       ack;
memResult_t result;

testRow_t    rowTable[$];
logic [7:0]  shadowMem [0:MEM_SLOTS*SLOT_BYTES-1];
logic        shadowTag [0:MEM_SLOTS-1];
logic [31:0] lfsrState;
int          errorCount = 0;
int          rowsFailed = 0;
int          cycleCount = 0;
int          cycleLimit = 0;

memOpUnit u_memOpUnit (
	.clk     (clk),
	.rstN    (rstN),
	.req     (req),
	.request (request),
	.ack     (ack),
	.result  (result)
);

always #4 clk = ~clk;

// Guards every wait on ack, the limit follows the table length
always @(posedge clk)
begin
	cycleCount <= cycleCount + 1;
	if (cycleCount >= cycleLimit)
	begin
		$display("Timeout after %0d cycles, the DUT never completed the handshake", cycleCount);
		$display("Test failures found");
		$finish;
	end
end

// Galois form of x^32 + x^22 + x^2 + x + 1, the bit taken is the low bit
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	if (state[0])
		return (state >> 1) ^ 32'h80200003;
	return state >> 1;
endfunction

task automatic nextStoreData(output logic [63:0] value);
	for (int i = 0; i < 64; i++)
	begin
		value[i] = lfsrState[0];
		lfsrState = lfsrStep(lfsrState);
	end
endtask

task automatic addRow(input logic [6:0] opcode, input logic [2:0] sizeFunc,
	input logic [31:0] base, input logic [11:0] disp, input logic expFault,
	input logic [3:0] holdCycles);
	rowTable.push_back({opcode, sizeFunc, base, disp, expFault, holdCycles});
endtask

// ==================================================
// Shadow memory model
// ==================================================

// Updates the shadow state and returns the data and tag the row should see
task automatic modelRow(input testRow_t row, input logic [63:0] storeData,
	output logic [63:0] expData, output logic expTag);
	logic [31:0] fullAddr;
	logic [8:0]  addr;
	int          slot;
	int          nBytes;
	fullAddr = row.base + {{20{row.disp[11]}}, row.disp};
	addr = fullAddr[8:0];
	slot = addr / SLOT_BYTES;
	nBytes = 1 << row.sizeFunc;
	expData = '0;
	expTag = 1'b0;
	// A faulting row neither returns data nor touches the shadow
	if (row.expFault)
		return;
	case (row.opcode)
		OP_LDX, OP_LDXU:
		begin
			for (int k = 0; k < nBytes; k++)
				expData[k*8 +: 8] = shadowMem[addr + k];
			// Signed loads copy the top loaded bit upward
			if (row.opcode == OP_LDX && nBytes < 8 && expData[nBytes*8-1])
				for (int b = nBytes * 8; b < 64; b++)
					expData[b] = 1'b1;
		end
		OP_STX:
		begin
			for (int k = 0; k < nBytes; k++)
				shadowMem[addr + k] = storeData[k*8 +: 8];
			shadowTag[slot] = 1'b0;
		end
		OP_LDCAPX:
		begin
			for (int k = 0; k < SLOT_BYTES; k++)
				expData[k*8 +: 8] = shadowMem[addr + k];
			expTag = shadowTag[slot];
		end
		OP_STCAPX:
		begin
			for (int k = 0; k < SLOT_BYTES; k++)
				shadowMem[addr + k] = storeData[k*8 +: 8];
			shadowTag[slot] = 1'b1;
		end
		// Tag gather, bit i is slot group*8+i
		OP_CAP:
			for (int i = 0; i < TAG_GROUP; i++)
				expData[i] = shadowTag[(slot / TAG_GROUP) * TAG_GROUP + i];
		default:
		begin
		end
	endcase
endtask

// ==================================================
// One four-phase transaction per row
// ==================================================

task automatic runRow(input int idx);
	testRow_t    row;
	logic [63:0] storeData;
	logic [63:0] expData;
	logic        expTag;
	logic [31:0] instrBits;
	memResult_t  heldResult;
	int          rowErrors;
	row = rowTable[idx];
	rowErrors = 0;
	nextStoreData(storeData);
	// The row index doubles as rd so the echo is checked too
	instrBits = {row.opcode, idx[4:0], 5'd0, row.sizeFunc, row.disp};
	modelRow(row, storeData, expData, expTag);
	@(posedge clk);
	request <= {instrBits, row.base, storeData};
	req <= 1'b1;
	@(negedge clk);
	while (!ack)
		@(negedge clk);
	if (result.data !== expData)
	begin
		$display("[FAIL] %0t row %0d result.data expected %h got %h", $time, idx, expData,
			result.data);
		rowErrors++;
	end
	if (result.tag !== expTag)
	begin
		$display("[FAIL] %0t row %0d result.tag expected %b got %b", $time, idx, expTag,
			result.tag);
		rowErrors++;
	end
	if (result.rd !== idx[4:0])
	begin
		$display("[FAIL] %0t row %0d result.rd expected %0d got %0d", $time, idx, idx[4:0],
			result.rd);
		rowErrors++;
	end
	if (result.fault !== row.expFault)
	begin
		$display("[FAIL] %0t row %0d result.fault expected %b got %b", $time, idx,
			row.expFault, result.fault);
		rowErrors++;
	end
	// Keep req high for a while, nothing may move
	heldResult = result;
	for (int h = 0; h < row.holdCycles; h++)
	begin
		@(negedge clk);
		if (ack !== 1'b1)
		begin
			$display("[FAIL] %0t row %0d ack expected 1 got %b", $time, idx, ack);
			rowErrors++;
		end
		if (result !== heldResult)
		begin
			$display("[FAIL] %0t row %0d result expected %h got %h", $time, idx, heldResult,
				result);
			rowErrors++;
		end
	end
	@(posedge clk);
	req <= 1'b0;
	@(negedge clk);
	while (ack)
		@(negedge clk);
	errorCount += rowErrors;
	if (rowErrors != 0)
		rowsFailed++;
	$display("Row %0d opcode %h func %0d base %h disp %h: %s", idx, row.opcode, row.sizeFunc,
		row.base, row.disp, (rowErrors == 0) ? "ok" : "mismatch");
endtask

task automatic buildTable();
	// Fresh memory reads back as zero everywhere
	addRow(OP_LDX, SZ_OCTA, 32'h100, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDCAPX, SZ_OCTA, 32'h1f8, 12'h000, 1'b0, 4'd0);
	addRow(OP_CAP, FN_CLOADTAGS, 32'h000, 12'h000, 1'b0, 4'd0);
	// Integer stores and loads of every size
	addRow(OP_STX, SZ_OCTA, 32'h010, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDX, SZ_BYTE, 32'h010, 12'h003, 1'b0, 4'd0);
	addRow(OP_LDXU, SZ_BYTE, 32'h010, 12'h003, 1'b0, 4'd0);
	addRow(OP_LDX, SZ_HALF, 32'h016, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDXU, SZ_HALF, 32'h016, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDX, SZ_WORD, 32'h014, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDXU, SZ_WORD, 32'h014, 12'h000, 1'b0, 4'd0);
	// Negative displacement lands on 0x21
	addRow(OP_STX, SZ_BYTE, 32'h030, 12'hff1, 1'b0, 4'd0);
	addRow(OP_STX, SZ_HALF, 32'h022, 12'h000, 1'b0, 4'd0);
	addRow(OP_STX, SZ_WORD, 32'h024, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDX, SZ_OCTA, 32'h020, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDXU, SZ_BYTE, 32'h021, 12'h000, 1'b0, 4'd0);
	// Capability round trip, then a byte store kills the tag
	addRow(OP_STCAPX, SZ_OCTA, 32'h040, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDCAPX, SZ_OCTA, 32'h040, 12'h000, 1'b0, 4'd3);
	addRow(OP_STX, SZ_BYTE, 32'h045, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDCAPX, SZ_OCTA, 32'h040, 12'h000, 1'b0, 4'd0);
	// Tags in group 1 end up as slots 9, 11 and 14
	addRow(OP_STCAPX, SZ_OCTA, 32'h048, 12'h000, 1'b0, 4'd0);
	addRow(OP_STCAPX, SZ_OCTA, 32'h058, 12'h000, 1'b0, 4'd0);
	addRow(OP_STCAPX, SZ_OCTA, 32'h070, 12'h000, 1'b0, 4'd0);
	addRow(OP_CAP, FN_CLOADTAGS, 32'h063, 12'h000, 1'b0, 4'd2);
	addRow(OP_CAP, FN_CLOADTAGS, 32'h008, 12'h000, 1'b0, 4'd0);
	// Upper address bits are dropped and negative offsets wrap
	addRow(OP_LDCAPX, SZ_OCTA, 32'h12340248, 12'h000, 1'b0, 4'd0);
	addRow(OP_STCAPX, SZ_OCTA, 32'h000, 12'hff8, 1'b0, 4'd0);
	addRow(OP_LDCAPX, SZ_OCTA, 32'h1f8, 12'h000, 1'b0, 4'd0);
	// Faulting rows, memory must stay as it was
	addRow(OP_STX, SZ_HALF, 32'h031, 12'h000, 1'b1, 4'd2);
	addRow(OP_STX, SZ_WORD, 32'h032, 12'h000, 1'b1, 4'd0);
	addRow(OP_LDX, SZ_OCTA, 32'h044, 12'h000, 1'b1, 4'd0);
	addRow(OP_STCAPX, SZ_OCTA, 32'h04c, 12'h000, 1'b1, 4'd0);
	addRow(OP_LDCAPX, SZ_OCTA, 32'h048, 12'h000, 1'b0, 4'd0);
	addRow(7'h30, SZ_OCTA, 32'h010, 12'h000, 1'b1, 4'd0);
	addRow(OP_CAP, 3'd1, 32'h040, 12'h000, 1'b1, 4'd0);
	addRow(OP_NOP, SZ_BYTE, 32'h010, 12'h000, 1'b1, 4'd0);
	addRow(OP_LDX, SZ_OCTA, 32'h030, 12'h000, 1'b0, 4'd0);
	addRow(OP_LDX, SZ_OCTA, 32'h010, 12'h000, 1'b0, 4'd0);
endtask

initial
begin
	clk = 1'b0;
	rstN = 1'b0;
	req = 1'b0;
	request = '0;
	lfsrState = 32'h767df26d;
	for (int i = 0; i < MEM_SLOTS * SLOT_BYTES; i++)
		shadowMem[i] = 8'h00;
	for (int i = 0; i < MEM_SLOTS; i++)
		shadowTag[i] = 1'b0;
	buildTable();
	cycleLimit = rowTable.size() * 12 + 50;
	repeat (5) @(posedge clk);
	rstN <= 1'b1;
	@(negedge clk);
	if (ack !== 1'b0)
	begin
		$display("[FAIL] %0t ack after reset expected 0 got %b", $time, ack);
		errorCount++;
	end
	for (int r = 0; r < rowTable.size(); r++)
		runRow(r);
	$display("Rows %0d, failed rows %0d, check errors %0d", rowTable.size(), rowsFailed,
		errorCount);
	if (errorCount == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
end

endmodule

// File: verilog/memOpDecoder.sv
`timescale 1ns/1ps

module memOpDecoder import memOpPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    start,
	input  memReq_t request,
	output logic    opValid,
	output memOp_t  op
);

// Integer loads, signed and unsigned
function automatic logic fnIsLoad(input instruction_t instr);
	case (instr.opcode)
		OP_LDX, OP_LDXU: return 1'b1;
		default:         return 1'b0;
	endcase
endfunction

function automatic logic fnIsStore(input instruction_t instr);
	return instr.opcode == OP_STX;
endfunction

function automatic logic fnIsCLoad(input instruction_t instr);
	return instr.opcode == OP_LDCAPX;
endfunction

function automatic logic fnIsCStore(input instruction_t instr);
	return instr.opcode == OP_STCAPX;
endfunction

// Tag gather lives under OP_CAP and needs its own function code
function automatic logic fnIsCLoadTags(input instruction_t instr);
	if (instr.opcode != OP_CAP)
		return 1'b0;
	case (capFunc_e'(instr.sizeFunc))
		FN_CLOADTAGS: return 1'b1;
		default:      return 1'b0;
	endcase
endfunction

opKind_e kind;
logic    sizeOk;

// Only the four defined access sizes are legal for integer accesses
assign sizeOk = request.instr.sizeFunc <= SZ_OCTA;

// Merge the separate checks into one kind, OP_NOP and unknown codes land in illegal
always_comb
begin
	if (fnIsLoad(request.instr) && sizeOk)
		kind = KIND_LOAD;
	else if (fnIsStore(request.instr) && sizeOk)
		kind = KIND_STORE;
	else if (fnIsCLoad(request.instr))
		kind = KIND_CLOAD;
	else if (fnIsCStore(request.instr))
		kind = KIND_CSTORE;
	else if (fnIsCLoadTags(request.instr))
		kind = KIND_CLOADTAGS;
	else
		kind = KIND_ILLEGAL;
end

always_ff @(posedge clk)
begin
	if (!rstN)
		opValid <= 1'b0;
	else
		opValid <= start;
end

// Operation payload is captured on the start pulse only
always_ff @(posedge clk)
begin
	if (start)
	begin
		op.kind <= kind;
		// Capability accesses always move a whole slot
		if (kind == KIND_LOAD || kind == KIND_STORE)
			op.size <= memSize_e'(request.instr.sizeFunc);
		else
			op.size <= SZ_OCTA;
		op.isUnsigned <= request.instr.opcode == OP_LDXU;
		op.rd <= request.instr.rd;
		op.base <= request.base;
		op.disp <= {{20{request.instr.disp[11]}}, request.instr.disp};
		op.storeData <= request.storeData;
	end
end

endmodule

// File: verilog/memOpExecute.sv
`timescale 1ns/1ps

module memOpExecute import memOpPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        opValid,
	input  memOp_t      op,
	output logic        exValid,
	output memOp_t      exOp,
	output logic [63:0] rawData,
	output logic        rawTag,
	output logic        fault
);

// Byte lane mask of an access within its slot
function automatic logic [SLOT_BYTES-1:0] fnLaneMask(
	input memSize_e               size,
	input logic [OFFSET_BITS-1:0] offset
);
	logic [2*SLOT_BYTES-1:0] mask;
	case (size)
		SZ_BYTE: mask = 16'h0001;
		SZ_HALF: mask = 16'h0003;
		SZ_WORD: mask = 16'h000f;
		default: mask = 16'h00ff;
	endcase
	mask = mask << offset;
	return mask[SLOT_BYTES-1:0];
endfunction

// Tagged data memory, one tag bit per slot
logic [63:0]          dataMem [MEM_SLOTS];
logic [MEM_SLOTS-1:0] tagMem;

logic [31:0]            fullAddr;
logic [ADDR_BITS-1:0]   effAddr;
logic [SLOT_BITS-1:0]   slot;
logic [OFFSET_BITS-1:0] offset;
logic [GROUP_BITS-1:0]  group;
logic                   misaligned;
logic                   opFault;
logic [SLOT_BYTES-1:0]  byteEn;
logic [63:0]            laneData;

// ==================================================
// Address and fault
// ==================================================

// Effective address wraps at 2^ADDR_BITS
assign fullAddr = op.base + op.disp;
assign effAddr = fullAddr[ADDR_BITS-1:0];
assign slot = effAddr[ADDR_BITS-1:OFFSET_BITS];
assign offset = effAddr[OFFSET_BITS-1:0];
// The top slot bits pick the tag group
assign group = slot[SLOT_BITS-1 -: GROUP_BITS];

always_comb
begin
	case (op.kind)
		KIND_LOAD, KIND_STORE:
			case (op.size)
				SZ_HALF: misaligned = offset[0];
				SZ_WORD: misaligned = |offset[1:0];
				SZ_OCTA: misaligned = |offset;
				default: misaligned = 1'b0;
			endcase
		// Capabilities must sit on a slot boundary
		KIND_CLOAD, KIND_CSTORE:
			misaligned = |offset;
		default:
			misaligned = 1'b0;
	endcase
end

assign opFault = misaligned || (op.kind == KIND_ILLEGAL);

// Store data moved up to its byte offset
assign byteEn = fnLaneMask(op.size, offset);
assign laneData = op.storeData << {offset, 3'b000};

// ==================================================
// Memory update
// ==================================================

always_ff @(posedge clk)
begin
	if (!rstN)
	begin
		exValid <= 1'b0;
		tagMem <= '0;
		for (int i = 0; i < MEM_SLOTS; i++)
			dataMem[i] <= '0;
	end
	else
	begin
		exValid <= opValid;
		// A faulting operation leaves memory untouched
		if (opValid && !opFault)
		begin
			case (op.kind)
				KIND_STORE:
				begin
					for (int b = 0; b < SLOT_BYTES; b++)
						if (byteEn[b])
							dataMem[slot][b*8 +: 8] <= laneData[b*8 +: 8];
					// Any integer write destroys the capability
					tagMem[slot] <= 1'b0;
				end
				KIND_CSTORE:
				begin
					dataMem[slot] <= op.storeData;
					tagMem[slot] <= 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end
end

// Read side, sees memory as it was before this operation
always_ff @(posedge clk)
begin
	if (opValid)
	begin
		exOp <= op;
		fault <= opFault;
		rawTag <= 1'b0;
		case (op.kind)
			KIND_CLOAD:
			begin
				rawData <= dataMem[slot];
				rawTag <= tagMem[slot];
			end
			KIND_CLOADTAGS:
				rawData <= {{(64-TAG_GROUP){1'b0}}, tagMem[group*TAG_GROUP +: TAG_GROUP]};
			// Integer loads get the slot shifted down to byte 0
			default:
				rawData <= dataMem[slot] >> {offset, 3'b000};
		endcase
	end
end

endmodule

// File: verilog/memOpPkg.sv
package memOpPkg;

// ==================================================
// Memory geometry
// ==================================================

// Number of capability slots in the local data memory
localparam int MEM_SLOTS = 64;
// Each slot is one 64-bit capability word
localparam int SLOT_BYTES = 8;
// Byte address bits in use, upper address bits are dropped
localparam int ADDR_BITS = 9;
// Slots whose tags come back from one tag gather
localparam int TAG_GROUP = 8;
// Derived index widths
localparam int SLOT_BITS = $clog2(MEM_SLOTS);
localparam int OFFSET_BITS = $clog2(SLOT_BYTES);
localparam int GROUP_BITS = SLOT_BITS - $clog2(TAG_GROUP);

// ==================================================
// Instruction encodings
// ==================================================

typedef enum logic [6:0] {
	OP_NOP    = 7'h00,
	OP_LDX    = 7'h20,
	OP_LDXU   = 7'h21,
	OP_STX    = 7'h22,
	OP_LDCAPX = 7'h24,
	OP_STCAPX = 7'h25,
	OP_CAP    = 7'h26
} opcode_e;

// Function codes under OP_CAP, everything else is illegal
typedef enum logic [2:0] {
	FN_CLOADTAGS = 3'd4
} capFunc_e;

// Access sizes, codes 4 to 7 are not defined
typedef enum logic [2:0] {
	SZ_BYTE = 3'd0,
	SZ_HALF = 3'd1,
	SZ_WORD = 3'd2,
	SZ_OCTA = 3'd3
} memSize_e;

typedef enum logic [2:0] {
	KIND_LOAD      = 3'd0,
	KIND_STORE     = 3'd1,
	KIND_CLOAD     = 3'd2,
	KIND_CSTORE    = 3'd3,
	KIND_CLOADTAGS = 3'd4,
	KIND_ILLEGAL   = 3'd7
} opKind_e;

// ==================================================
// Structures passed between stages
// ==================================================

// The sizeFunc field is the access size, or the function code for OP_CAP
typedef struct packed {
	opcode_e            opcode;
	logic [4:0]         rd;
	logic [4:0]         rs1;
	logic [2:0]         sizeFunc;
	logic signed [11:0] disp;
} instruction_t;

typedef struct packed {
	instruction_t instr;
	logic [31:0]  base;
	logic [63:0]  storeData;
} memReq_t;

// Decoded operation, disp is already sign-extended
typedef struct packed {
	opKind_e     kind;
	memSize_e    size;
	logic        isUnsigned;
	logic [4:0]  rd;
	logic [31:0] base;
	logic [31:0] disp;
	logic [63:0] storeData;
} memOp_t;

typedef struct packed {
	logic [63:0] data;
	logic        tag;
	logic [4:0]  rd;
	logic        fault;
} memResult_t;

endpackage

// File: verilog/memOpResult.sv
`timescale 1ns/1ps

module memOpResult import memOpPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        exValid,
	input  memOp_t      exOp,
	input  logic [63:0] rawData,
	input  logic        rawTag,
	input  logic        fault,
	output logic        resultValid,
	output memResult_t  result
);

// Truncate to the access size, then sign or zero extend
function automatic logic [63:0] fnExtend(
	input logic [63:0] raw,
	input memSize_e    size,
	input logic        isUnsigned
);
	case (size)
		SZ_BYTE:
			return isUnsigned ? {56'b0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
		SZ_HALF:
			return isUnsigned ? {48'b0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
		SZ_WORD:
			return isUnsigned ? {32'b0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
		default:
			return raw;
	endcase
endfunction

logic [63:0] nextData;
logic        nextTag;

// Stores, faults and illegal kinds all return zero data
always_comb
begin
	nextData = '0;
	nextTag = 1'b0;
	if (!fault)
	begin
		case (exOp.kind)
			KIND_LOAD:
				nextData = fnExtend(rawData, exOp.size, exOp.isUnsigned);
			// Only a capability load carries a tag out
			KIND_CLOAD:
			begin
				nextData = rawData;
				nextTag = rawTag;
			end
			// Gathered tags already sit in the low byte
			KIND_CLOADTAGS:
				nextData = rawData;
			default:
			begin
			end
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (!rstN)
		resultValid <= 1'b0;
	else
		resultValid <= exValid;
end

// Result stays put until the next operation reaches this stage
always_ff @(posedge clk)
begin
	if (exValid)
	begin
		result.data <= nextData;
		result.tag <= nextTag;
		result.rd <= exOp.rd;
		result.fault <= fault;
	end
end

endmodule

// File: verilog/memOpUnit.sv
`timescale 1ns/1ps

module memOpUnit import memOpPkg::*; (
	input  logic       clk,
	input  logic       rstN,
	input  logic       req,
	input  memReq_t    request,
	output logic       ack,
	output memResult_t result
);

// Handshake FSM, one operation in flight at a time
typedef enum logic [1:0] {
	IDLE,
	BUSY,
	DONE
} hsState_e;

hsState_e    state;
logic        start;
logic        opValid;
memOp_t      op;
logic        exValid;
memOp_t      exOp;
logic [63:0] rawData;
logic        rawTag;
logic        fault;
logic        resultValid;

// ==================================================
// Four-phase handshake
// ==================================================

always_ff @(posedge clk)
begin
	if (!rstN)
	begin
		state <= IDLE;
		start <= 1'b0;
		ack <= 1'b0;
	end
	else
	begin
		// Start is a single cycle pulse
		start <= 1'b0;
		case (state)
			IDLE:
				if (req)
				begin
					start <= 1'b1;
					state <= BUSY;
				end
			BUSY:
				if (resultValid)
				begin
					ack <= 1'b1;
					state <= DONE;
				end
			// Hold ack while the requester keeps req high
			DONE:
				if (!req)
				begin
					ack <= 1'b0;
					state <= IDLE;
				end
			default:
				state <= IDLE;
		endcase
	end
end

memOpDecoder u_memOpDecoder (
	.clk     (clk),
	.rstN    (rstN),
	.start   (start),
	.request (request),
	.opValid (opValid),
	.op      (op)
);

memOpExecute u_memOpExecute (
	.clk     (clk),
	.rstN    (rstN),
	.opValid (opValid),
	.op      (op),
	.exValid (exValid),
	.exOp    (exOp),
	.rawData (rawData),
	.rawTag  (rawTag),
	.fault   (fault)
);

memOpResult u_memOpResult (
	.clk         (clk),
	.rstN        (rstN),
	.exValid     (exValid),
	.exOp        (exOp),
	.rawData     (rawData),
	.rawTag      (rawTag),
	.fault       (fault),
	.resultValid (resultValid),
	.result      (result)
);

endmodule
